// File: Makefile
# Verilator build and run for the transmit I/Q interface testbench
VERILATOR ?= verilator
TOP       ?= tb_tx_iq_top
FILELIST  ?= tx_iq.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: csi_fuzzer.sv
// Channel-state fuzzer, three-tap complex FIR with optional 90 degree tap rotation
module csi_fuzzer (
    input  logic                clk,
    input  logic                rstn,
    input  tx_iq_pkg::iq_pair_t iq,
    input  logic                iq_valid,
    input  tx_iq_pkg::tap_t     bb_gain1,
    input  tx_iq_pkg::tap_t     bb_gain2,
    input  logic                bb_gain1_rot90,
    input  logic                bb_gain2_rot90,
    output tx_iq_pkg::iq_pair_t iq_out
);

    localparam int IQ_W = $bits(tx_iq_pkg::iq_t);
    localparam int PW   = IQ_W + $bits(tx_iq_pkg::tap_t);

    tx_iq_pkg::iq_pair_t dly1;  // Previous sample
    tx_iq_pkg::iq_pair_t dly2;  // Two samples back
    tx_iq_pkg::iq_pair_t term1;
    tx_iq_pkg::iq_pair_t term2;
    tx_iq_pkg::iq_t      sum_i;
    tx_iq_pkg::iq_t      sum_q;

    // Scaled tap product of one delayed sample
    function automatic tx_iq_pkg::iq_pair_t tap_term(input tx_iq_pkg::iq_pair_t s,
                                                     input tx_iq_pkg::tap_t g,
                                                     input logic rot);
        tx_iq_pkg::iq_t  si;
        tx_iq_pkg::iq_t  sq;
        tx_iq_pkg::iq_t  ri;
        tx_iq_pkg::iq_t  rq;
        logic signed [PW-1:0] pi;
        logic signed [PW-1:0] pq;
        si = s[IQ_W-1:0];
        sq = s[2*IQ_W-1:IQ_W];
        ri = rot ? -sq : si;  // (I, Q) becomes (-Q, I)
        rq = rot ? si : sq;
        pi = ri * g;
        pq = rq * g;
        return {pq[tx_iq_pkg::TAP_SHIFT +: IQ_W], pi[tx_iq_pkg::TAP_SHIFT +: IQ_W]};
    endfunction

    always_comb begin
        term1 = tap_term(dly1, bb_gain1, bb_gain1_rot90);
        term2 = tap_term(dly2, bb_gain2, bb_gain2_rot90);
        sum_i = iq[IQ_W-1:0] + term1[IQ_W-1:0] + term2[IQ_W-1:0];  // Wraps
        sum_q = iq[2*IQ_W-1:IQ_W] + term1[2*IQ_W-1:IQ_W] + term2[2*IQ_W-1:IQ_W];
    end

    // Advances only on RF ready
    always_ff @(posedge clk) begin
        if (!rstn) begin
            dly1   <= '0;
            dly2   <= '0;
            iq_out <= '0;
        end else if (iq_valid) begin
            dly1   <= iq;
            dly2   <= dly1;
            iq_out <= {sum_q, sum_i};
        end
    end

endmodule

// File: tb_tx_iq_top.sv
// Directed testbench checking the APB registers and the sample path against a model
module tb_tx_iq_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH  = 16;
    localparam int CYCLE_LIMIT = 3000;  // Far above the length of the directed tests

    logic                clk = 1'b0;
    logic                rstn;
    logic [3:0]          paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    tx_iq_pkg::iq_t      rf_i;
    tx_iq_pkg::iq_t      rf_q;
    logic                rf_iq_valid;
    logic                tx_hold;
    logic                wifi_iq_ready;
    logic                wifi_iq_valid;
    tx_iq_pkg::iq_pair_t wifi_iq_pack;

    tx_iq_pkg::iq_pair_t fifo_q [$];     // Scaled samples expected in the FIFO
    tx_iq_pkg::iq_pair_t dly1_m = '0;    // Model delay line
    tx_iq_pkg::iq_pair_t dly2_m = '0;
    tx_iq_pkg::gain_t    gain_m = tx_iq_pkg::GAIN_RST;
    tx_iq_pkg::tap_t     tap1_m = '0;
    tx_iq_pkg::tap_t     tap2_m = '0;
    logic                rot1_m = 1'b0;
    logic                rot2_m = 1'b0;
    string               test_name = "reset";
    int                  cycles = 0;

    tx_iq_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles in test %s", cycles, test_name);
            $display("*** FAILED ***");
            $fatal(1, "Timeout");
        end
    end

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected %h actual %h",
                     test_name, what, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch");
        end
    endtask

    // Ends 2 ns after the last edge where all stimulus changes
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                            input logic exp_err, output logic [31:0] rdata);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        wait_cycles(1);
        penable = 1'b1;
        #1;
        rdata = prdata;  // Mid access phase
        check_eq("pready", 32'd1, 32'(pready));
        check_eq("pslverr", 32'(exp_err), 32'(pslverr));
        wait_cycles(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] ignored;
        apb_xfer(1'b1, addr, data, exp_err, ignored);
    endtask

    task automatic apb_read(input logic [3:0] addr, input logic [31:0] expected,
                            input logic exp_err);
        logic [31:0] rdata;
        apb_xfer(1'b0, addr, 32'h0, exp_err, rdata);
        check_eq("read data", expected, rdata);
    endtask

    task automatic set_gain(input tx_iq_pkg::gain_t g);
        apb_write(tx_iq_pkg::REG_GAIN, 32'(g), 1'b0);
        gain_m = g;
    endtask

    task automatic set_fuzz(input tx_iq_pkg::tap_t t1, input logic r1,
                            input tx_iq_pkg::tap_t t2, input logic r2);
        logic [31:0] word;
        word       = '0;
        word[5:0]  = t1;
        word[6]    = r1;
        word[13:8] = t2;
        word[14]   = r2;
        apb_write(tx_iq_pkg::REG_FUZZ, word, 1'b0);
        tap1_m = t1;
        rot1_m = r1;
        tap2_m = t2;
        rot2_m = r2;
    endtask

    // Gain model with the product shifted by 7 and cut to 16 bits
    function automatic tx_iq_pkg::iq_t scale_component(input tx_iq_pkg::iq_t x,
                                                       input tx_iq_pkg::gain_t g);
        int prod;
        prod = int'(x) * int'(g);
        return tx_iq_pkg::iq_t'(prod >>> tx_iq_pkg::GAIN_SHIFT);
    endfunction

    function automatic tx_iq_pkg::iq_pair_t tap_product(input tx_iq_pkg::iq_pair_t s,
                                                       input tx_iq_pkg::tap_t g,
                                                       input logic rot);
        tx_iq_pkg::iq_t ri;
        tx_iq_pkg::iq_t rq;
        int             prod_i;
        int             prod_q;
        ri = rot ? -s[31:16] : s[15:0];  // Rotation maps (I, Q) to (-Q, I)
        rq = rot ? s[15:0] : s[31:16];
        prod_i = int'(ri) * int'(g);
        prod_q = int'(rq) * int'(g);
        return {tx_iq_pkg::iq_t'(prod_q >>> tx_iq_pkg::TAP_SHIFT),
                tx_iq_pkg::iq_t'(prod_i >>> tx_iq_pkg::TAP_SHIFT)};
    endfunction

    task automatic push_sample(input tx_iq_pkg::iq_t i, input tx_iq_pkg::iq_t q,
                               input logic kept);
        rf_i        = i;
        rf_q        = q;
        rf_iq_valid = 1'b1;
        if (kept) begin
            fifo_q.push_back({scale_component(q, gain_m), scale_component(i, gain_m)});
        end
        wait_cycles(1);
        rf_iq_valid = 1'b0;
    endtask

    // One ready cycle with the FIR model run on the head or on zero when empty
    task automatic pop_sample();
        tx_iq_pkg::iq_pair_t head;
        tx_iq_pkg::iq_pair_t t1;
        tx_iq_pkg::iq_pair_t t2;
        tx_iq_pkg::iq_pair_t expected;
        head = '0;
        if (fifo_q.size() > 0) begin
            head = fifo_q.pop_front();
        end
        t1 = tap_product(dly1_m, tap1_m, rot1_m);
        t2 = tap_product(dly2_m, tap2_m, rot2_m);
        expected[15:0]  = head[15:0] + t1[15:0] + t2[15:0];    // Wraps per component
        expected[31:16] = head[31:16] + t1[31:16] + t2[31:16];
        dly2_m = dly1_m;
        dly1_m = head;
        wifi_iq_ready = 1'b1;
        wait_cycles(1);
        wifi_iq_ready = 1'b0;
        check_eq("wifi_iq_pack", expected, wifi_iq_pack);
        check_eq("wifi_iq_valid", 32'd1, 32'(wifi_iq_valid));
    endtask

    task automatic register_access();
        logic [31:0] ignored;
        test_name = "registers";
        apb_read(tx_iq_pkg::REG_THRESHOLD, 32'd400, 1'b0);
        apb_read(tx_iq_pkg::REG_GAIN, 32'd128, 1'b0);
        apb_read(tx_iq_pkg::REG_FUZZ, 32'd0, 1'b0);
        apb_read(tx_iq_pkg::REG_STATUS, 32'h0001_0000, 1'b0);  // Empty with count 0
        // Readback masked to the fields
        apb_write(tx_iq_pkg::REG_THRESHOLD, 32'hFFFF_F123, 1'b0);
        apb_read(tx_iq_pkg::REG_THRESHOLD, 32'h0000_0123, 1'b0);
        apb_write(tx_iq_pkg::REG_GAIN, 32'h5A5A_A2A5, 1'b0);
        apb_read(tx_iq_pkg::REG_GAIN, 32'h0000_02A5, 1'b0);
        apb_write(tx_iq_pkg::REG_FUZZ, 32'hFFFF_FFFF, 1'b0);
        apb_read(tx_iq_pkg::REG_FUZZ, 32'h0000_7F7F, 1'b0);
        // Unmapped offsets and a status write
        apb_write(4'h2, 32'h0000_0077, 1'b1);
        apb_write(tx_iq_pkg::REG_STATUS, 32'h0000_0005, 1'b1);
        apb_xfer(1'b0, 4'h6, 32'h0, 1'b1, ignored);
        apb_read(tx_iq_pkg::REG_STATUS, 32'h0001_0000, 1'b0);
        apb_read(tx_iq_pkg::REG_THRESHOLD, 32'h0000_0123, 1'b0);
        apb_write(tx_iq_pkg::REG_THRESHOLD, 32'd400, 1'b0);
        set_gain(tx_iq_pkg::gain_t'(128));
        set_fuzz('0, 1'b0, '0, 1'b0);
    endtask

    task automatic unity_passthrough();
        test_name = "passthrough";
        for (int n = 0; n < 8; n++) begin
            push_sample(tx_iq_pkg::iq_t'($urandom), tx_iq_pkg::iq_t'($urandom), 1'b1);
        end
        wait_cycles(2);  // Last write lands
        apb_read(tx_iq_pkg::REG_STATUS, 32'd8, 1'b0);
        for (int n = 0; n < 8; n++) begin
            pop_sample();
        end
        repeat (2) begin
            pop_sample();  // Empty FIFO pads with zero
        end
        apb_read(tx_iq_pkg::REG_STATUS, 32'h0001_0000, 1'b0);  // Reads while empty are ignored
    endtask

    task automatic gain_scaling();
        tx_iq_pkg::gain_t gains [2] = '{10'sd64, -10'sd200};
        test_name = "gain";
        foreach (gains[k]) begin
            set_gain(gains[k]);
            for (int n = 0; n < 6; n++) begin
                push_sample(tx_iq_pkg::iq_t'($urandom), tx_iq_pkg::iq_t'($urandom), 1'b1);
            end
            wait_cycles(2);
            for (int n = 0; n < 6; n++) begin
                pop_sample();
            end
        end
        set_gain(tx_iq_pkg::gain_t'(128));
    endtask

    task automatic hold_backpressure();
        int pushed;
        test_name = "hold";
        apb_write(tx_iq_pkg::REG_THRESHOLD, 32'd5, 1'b0);
        // One sample at a time so none is in flight when hold rises
        for (pushed = 0; pushed < FIFO_DEPTH && !tx_hold; pushed++) begin
            push_sample(tx_iq_pkg::iq_t'($urandom), tx_iq_pkg::iq_t'($urandom), 1'b1);
            wait_cycles(2);
        end
        check_eq("samples before hold", 32'd6, 32'(pushed));
        repeat (4) begin
            push_sample(tx_iq_pkg::iq_t'($urandom), tx_iq_pkg::iq_t'($urandom), 1'b0);
        end
        wait_cycles(2);
        check_eq("tx_hold high", 32'd1, 32'(tx_hold));
        apb_read(tx_iq_pkg::REG_STATUS, 32'd6, 1'b0);
        repeat (6) begin
            pop_sample();
            check_eq("tx_hold", 32'(fifo_q.size() > 5), 32'(tx_hold));
        end
        apb_write(tx_iq_pkg::REG_THRESHOLD, 32'd400, 1'b0);
    endtask

    task automatic fuzzer_taps();
        tx_iq_pkg::iq_t seq_i [6] = '{16'h1000, 16'h7FFF, 16'hF000, 16'h0400, 16'h8000, 16'h0001};
        tx_iq_pkg::iq_t seq_q [6] = '{16'h0800, 16'h8000, 16'h0123, 16'hFC00, 16'h7FFF, 16'hFFFF};
        test_name = "fuzzer";
        // Field 0x20 is the most negative 6-bit tap
        set_fuzz(tx_iq_pkg::tap_t'(6'h20), 1'b1, tx_iq_pkg::tap_t'(-16), 1'b0);
        foreach (seq_i[k]) begin
            push_sample(seq_i[k], seq_q[k], 1'b1);
        end
        wait_cycles(2);
        repeat (8) begin
            pop_sample();  // Last two flush zeros through the taps
        end
        set_fuzz('0, 1'b0, '0, 1'b0);
    endtask

    initial begin
        rstn          = 1'b0;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        rf_i          = '0;
        rf_q          = '0;
        rf_iq_valid   = 1'b0;
        wifi_iq_ready = 1'b0;
        void'($urandom(32'ha0645ab7));
        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;
        register_access();
        unity_passthrough();
        gain_scaling();
        hold_backpressure();
        fuzzer_taps();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: tx_gain_scale.sv
// Baseband gain stage, registered complex multiply with FIFO write strobe gated by hold
module tx_gain_scale (
    input  logic                clk,
    input  logic                rstn,
    input  tx_iq_pkg::iq_t      rf_i,
    input  tx_iq_pkg::iq_t      rf_q,
    input  logic                rf_iq_valid,
    input  logic                tx_hold,
    input  tx_iq_pkg::gain_t    bb_gain,
    output tx_iq_pkg::iq_pair_t scaled,
    output logic                scaled_wren
);

    localparam int IQ_W   = $bits(tx_iq_pkg::iq_t);
    localparam int PROD_W = IQ_W + $bits(tx_iq_pkg::gain_t);  // 26 bits

    logic signed [PROD_W-1:0] prod_i;
    logic signed [PROD_W-1:0] prod_q;

    // Products carry no control meaning
    always_ff @(posedge clk) begin
        prod_i <= rf_i * bb_gain;
        prod_q <= rf_q * bb_gain;
    end

    // Sample accepted only when the core is not held
    always_ff @(posedge clk) begin
        if (!rstn) begin
            scaled_wren <= 1'b0;
        end else begin
            scaled_wren <= rf_iq_valid & ~tx_hold;
        end
    end

    // Drop the fraction and the top bits, wraps on overflow
    assign scaled = {prod_q[tx_iq_pkg::GAIN_SHIFT +: IQ_W],
                     prod_i[tx_iq_pkg::GAIN_SHIFT +: IQ_W]};

endmodule

// File: tx_iq.f
tx_iq_pkg.sv
tx_iq_regs.sv
tx_gain_scale.sv
tx_iq_fifo.sv
csi_fuzzer.sv
tx_iq_intf.sv
tx_iq_top.sv
tb_tx_iq_top.sv

// File: tx_iq_fifo.sv
// Synchronous first-word-fall-through sample FIFO with occupancy count
module tx_iq_fifo #(
    parameter int FIFO_DEPTH = 512
) (
    input  logic                clk,
    input  logic                rstn,
    input  tx_iq_pkg::iq_pair_t din,
    input  logic                wr_en,
    input  logic                rd_en,
    output tx_iq_pkg::iq_pair_t dout,
    output logic                empty,
    output logic                full,
    output tx_iq_pkg::count_t   count
);

    localparam int AW = $clog2(FIFO_DEPTH);

    tx_iq_pkg::iq_pair_t mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_wr;
    logic          do_rd;

    assign empty = (count == '0);
    assign full  = (count == tx_iq_pkg::count_t'(FIFO_DEPTH));

    assign do_wr = wr_en & ~full;   // Drop when full
    assign do_rd = rd_en & ~empty;  // Ignore when empty

    assign dout = mem[rd_ptr];      // Head is visible without a read

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

// File: tx_iq_intf.sv
// Transmit sample path through gain, FIFO and fuzzer, with hold and zero padding
module tx_iq_intf #(
    parameter int FIFO_DEPTH = 512
) (
    input  logic                clk,
    input  logic                rstn,
    input  tx_iq_pkg::iq_t      rf_i,
    input  tx_iq_pkg::iq_t      rf_q,
    input  logic                rf_iq_valid,
    output logic                tx_hold,
    input  logic                wifi_iq_ready,
    output tx_iq_pkg::iq_pair_t wifi_iq_pack,
    output logic                wifi_iq_valid,
    input  tx_iq_pkg::count_t   tx_hold_threshold,
    input  tx_iq_pkg::gain_t    bb_gain,
    input  tx_iq_pkg::tap_t     bb_gain1,
    input  logic                bb_gain1_rot90,
    input  tx_iq_pkg::tap_t     bb_gain2,
    input  logic                bb_gain2_rot90,
    output tx_iq_pkg::count_t   fifo_count,
    output logic                fifo_empty
);

    tx_iq_pkg::iq_pair_t scaled;
    logic                scaled_wren;
    tx_iq_pkg::iq_pair_t fifo_dout;
    tx_iq_pkg::iq_pair_t fifo_head;  // Zero while empty

    assign tx_hold       = (fifo_count > tx_hold_threshold);  // Enough queued, stall core
    assign fifo_head     = fifo_empty ? '0 : fifo_dout;
    assign wifi_iq_valid = 1'b1;

    tx_gain_scale gain_i (
        .clk         (clk),
        .rstn        (rstn),
        .rf_i        (rf_i),
        .rf_q        (rf_q),
        .rf_iq_valid (rf_iq_valid),
        .tx_hold     (tx_hold),
        .bb_gain     (bb_gain),
        .scaled      (scaled),
        .scaled_wren (scaled_wren)
    );

    tx_iq_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
        .clk   (clk),
        .rstn  (rstn),
        .din   (scaled),
        .wr_en (scaled_wren),
        .rd_en (wifi_iq_ready),  // RF draws one per ready cycle
        .dout  (fifo_dout),
        .empty (fifo_empty),
        .full  (),               // Overflow handled inside the FIFO
        .count (fifo_count)
    );

    csi_fuzzer fuzz_i (
        .clk            (clk),
        .rstn           (rstn),
        .iq             (fifo_head),
        .iq_valid       (wifi_iq_ready),
        .bb_gain1       (bb_gain1),
        .bb_gain2       (bb_gain2),
        .bb_gain1_rot90 (bb_gain1_rot90),
        .bb_gain2_rot90 (bb_gain2_rot90),
        .iq_out         (wifi_iq_pack)
    );

endmodule

// File: tx_iq_pkg.sv
// Transmit I/Q interface package with sample types, scaling constants and register map
package tx_iq_pkg;

    typedef logic signed [15:0] iq_t;       // One I or Q component
    typedef logic        [31:0] iq_pair_t;  // Q in [31:16], I in [15:0]
    typedef logic signed [9:0]  gain_t;     // 128 is unity
    typedef logic signed [5:0]  tap_t;      // 32 is unity
    typedef logic        [9:0]  count_t;    // FIFO fill and hold threshold

    // Product right shifts
    localparam int GAIN_SHIFT = 7;
    localparam int TAP_SHIFT  = 5;

    // APB register offsets
    localparam logic [3:0] REG_THRESHOLD = 4'h0;
    localparam logic [3:0] REG_GAIN      = 4'h4;
    localparam logic [3:0] REG_FUZZ      = 4'h8;  // Taps and rotate flags
    localparam logic [3:0] REG_STATUS    = 4'hC;  // Read only

    // REG_FUZZ field positions
    localparam int FUZZ_TAP1_LSB = 0;
    localparam int FUZZ_ROT1_BIT = 6;
    localparam int FUZZ_TAP2_LSB = 8;
    localparam int FUZZ_ROT2_BIT = 14;

    // REG_STATUS empty flag
    localparam int STATUS_EMPTY_BIT = 16;

    // Register reset values
    localparam count_t THRESHOLD_RST = 10'd400;
    localparam gain_t  GAIN_RST      = 10'sd128;
    localparam tap_t   TAP_RST       = 6'sd0;

endpackage

// File: tx_iq_regs.sv
// APB register file holding hold threshold, gain and fuzzer taps, with FIFO status readback
module tx_iq_regs (
    input  logic                clk,
    input  logic                rstn,
    input  logic [3:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  tx_iq_pkg::count_t   fifo_count,
    input  logic                fifo_empty,
    output tx_iq_pkg::count_t   tx_hold_threshold,
    output tx_iq_pkg::gain_t    bb_gain,
    output tx_iq_pkg::tap_t     bb_gain1,
    output logic                bb_gain1_rot90,
    output tx_iq_pkg::tap_t     bb_gain2,
    output logic                bb_gain2_rot90
);

    logic access;    // APB access phase
    logic addr_ok;
    logic bad_acc;
    logic wr_en;

    assign access  = psel & penable;
    assign addr_ok = (paddr == tx_iq_pkg::REG_THRESHOLD) || (paddr == tx_iq_pkg::REG_GAIN) ||
                     (paddr == tx_iq_pkg::REG_FUZZ) || (paddr == tx_iq_pkg::REG_STATUS);
    assign bad_acc = ~addr_ok | (pwrite & (paddr == tx_iq_pkg::REG_STATUS));

    assign pready  = 1'b1;                  // No wait states
    assign pslverr = access & bad_acc;
    assign wr_en   = access & pwrite & ~bad_acc;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_hold_threshold <= tx_iq_pkg::THRESHOLD_RST;
            bb_gain           <= tx_iq_pkg::GAIN_RST;
            bb_gain1          <= tx_iq_pkg::TAP_RST;
            bb_gain1_rot90    <= 1'b0;
            bb_gain2          <= tx_iq_pkg::TAP_RST;
            bb_gain2_rot90    <= 1'b0;
        end else if (wr_en) begin
            case (paddr)
                tx_iq_pkg::REG_THRESHOLD: tx_hold_threshold <= pwdata[9:0];
                tx_iq_pkg::REG_GAIN:      bb_gain <= tx_iq_pkg::gain_t'(pwdata[9:0]);
                tx_iq_pkg::REG_FUZZ: begin
                    bb_gain1       <= tx_iq_pkg::tap_t'(pwdata[tx_iq_pkg::FUZZ_TAP1_LSB +: 6]);
                    bb_gain1_rot90 <= pwdata[tx_iq_pkg::FUZZ_ROT1_BIT];
                    bb_gain2       <= tx_iq_pkg::tap_t'(pwdata[tx_iq_pkg::FUZZ_TAP2_LSB +: 6]);
                    bb_gain2_rot90 <= pwdata[tx_iq_pkg::FUZZ_ROT2_BIT];
                end
                default: ;
            endcase
        end
    end

    // Readback mux, status is live
    always_comb begin
        prdata = '0;
        case (paddr)
            tx_iq_pkg::REG_THRESHOLD: prdata[9:0] = tx_hold_threshold;
            tx_iq_pkg::REG_GAIN:      prdata[9:0] = bb_gain;
            tx_iq_pkg::REG_FUZZ: begin
                prdata[tx_iq_pkg::FUZZ_TAP1_LSB +: 6] = bb_gain1;
                prdata[tx_iq_pkg::FUZZ_ROT1_BIT]      = bb_gain1_rot90;
                prdata[tx_iq_pkg::FUZZ_TAP2_LSB +: 6] = bb_gain2;
                prdata[tx_iq_pkg::FUZZ_ROT2_BIT]      = bb_gain2_rot90;
            end
            tx_iq_pkg::REG_STATUS: begin
                prdata[9:0]                          = fifo_count;
                prdata[tx_iq_pkg::STATUS_EMPTY_BIT] = fifo_empty;
            end
            default: ;
        endcase
    end

endmodule

// File: tx_iq_top.sv
// Transmit I/Q interface top joining the APB register file to the sample path
module tx_iq_top #(
    parameter int FIFO_DEPTH = 512
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic [3:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  tx_iq_pkg::iq_t      rf_i,
    input  tx_iq_pkg::iq_t      rf_q,
    input  logic                rf_iq_valid,
    output logic                tx_hold,
    input  logic                wifi_iq_ready,
    output tx_iq_pkg::iq_pair_t wifi_iq_pack,
    output logic                wifi_iq_valid
);

    tx_iq_pkg::count_t tx_hold_threshold;
    tx_iq_pkg::gain_t  bb_gain;
    tx_iq_pkg::tap_t   bb_gain1;
    logic              bb_gain1_rot90;
    tx_iq_pkg::tap_t   bb_gain2;
    logic              bb_gain2_rot90;
    tx_iq_pkg::count_t fifo_count;
    logic              fifo_empty;

    tx_iq_regs regs_i (
        .clk               (clk),
        .rstn              (rstn),
        .paddr             (paddr),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .pwdata            (pwdata),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .fifo_count        (fifo_count),
        .fifo_empty        (fifo_empty),
        .tx_hold_threshold (tx_hold_threshold),
        .bb_gain           (bb_gain),
        .bb_gain1          (bb_gain1),
        .bb_gain1_rot90    (bb_gain1_rot90),
        .bb_gain2          (bb_gain2),
        .bb_gain2_rot90    (bb_gain2_rot90)
    );

    tx_iq_intf #(.FIFO_DEPTH(FIFO_DEPTH)) intf_i (
        .clk               (clk),
        .rstn              (rstn),
        .rf_i              (rf_i),
        .rf_q              (rf_q),
        .rf_iq_valid       (rf_iq_valid),
        .tx_hold           (tx_hold),
        .wifi_iq_ready     (wifi_iq_ready),
        .wifi_iq_pack      (wifi_iq_pack),
        .wifi_iq_valid     (wifi_iq_valid),
        .tx_hold_threshold (tx_hold_threshold),
        .bb_gain           (bb_gain),
        .bb_gain1          (bb_gain1),
        .bb_gain1_rot90    (bb_gain1_rot90),
        .bb_gain2          (bb_gain2),
        .bb_gain2_rot90    (bb_gain2_rot90),
        .fifo_count        (fifo_count),
        .fifo_empty        (fifo_empty)
    );

endmodule
